// File: test/filter_vectors.txt
// per line: 32 raw samples, then 32 expected filtered samples, 16-bit hex
// four words per row, line A first, then line B
// line A raw
0000 0000 0400 0000
0000 0000 0000 0000
0000 0000 1000 F800
0000 0000 0000 0000
0000 0C00 0000 0000
0000 0000 0000 0000
0000 0000 0100 0000
0000 0000 0000 0000
// line A expected
0000 FE61 0400 FE61
0000 FFD2 0000 FF48
005C F984 133E F184
033E FF48 FFD2 0000
FB23 0C00 FB23 0000
FF76 0000 0000 FFF5
0000 FF98 0100 FF98
0000 FFF5 0000 0000
// line B raw
1400 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 8000 7C00 8000
0000 0000 0000 0000
0000 0000 FED4 0000
0000 0000 0000 0000
0000 0000 0000 0800
// line B expected
1400 F7E5 0000 FF1A
0000 0000 0000 0000
0000 0000 05C0 FA6E
39A0 8000 7FFF 8000
39A0 FA6E 05C0 000D
0000 007A FED4 007A
0000 000D 0000 0000
FFA4 FFA4 FC66 0466

// File: build.f
hdl/filter_pkg.sv
hdl/dual_port_ram.sv
hdl/fir_filter.sv
hdl/filtered_ram_swappable.sv
hdl/bank_swap_ctrl.sv
hdl/projection_filter_top.sv
test/tb_projection_filter.sv

// File: Makefile
# Verilator build and run for the projection filter testbench

VERILATOR ?= verilator
TOP       ?= tb_projection_filter
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_projection_filter.sv
`timescale 1ns/1ps

module tb_projection_filter;

    import filter_pkg::*;

    localparam int clk_period = 8;
    localparam int drive_delay = 1;
    localparam int reset_cycles = 10;
    localparam int fill_cycles = 1 + fill_delay + line_size;
    localparam int settle_cycles = 10;
    localparam int watchdog_cycles =
        4 * (reset_cycles + 2 * (fill_cycles + line_size + 10));

    logic                        clk;
    logic                        reset_n;
    logic                        load_we;
    logic [s_width-1:0]          load_addr;
    logic signed [raw_width-1:0] load_data;
    logic                        fill_kick;
    logic                        fill_done;
    logic                        swap;
    proc_req_t                   proc_req;
    proc_data_t                  proc_data;

    // per line, raw samples then expected filtered samples
    logic [15:0] vectors [0:4*line_size-1];

    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    projection_filter_top u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .fill_kick (fill_kick),
        .fill_done (fill_done),
        .swap      (swap),
        .proc_req  (proc_req),
        .proc_data (proc_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test never finished", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // inputs change just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic check_sample(input int line, input int addr, input logic [15:0] got,
                                input int port);
        logic [15:0] expected;
        expected = vectors[line * 2 * line_size + line_size + addr];
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("FAILED at %0t ns: line %0d port s%0d addr %0d read %h, expected %h",
                     $time, line, port, addr, got, expected);
        end
    endtask

    // one cycle with a random read of the processing bank when proc_line is valid
    task automatic step(input int proc_line);
        int a0;
        int a1;
        if (proc_line >= 0)
        begin
            a0 = int'((next_random() >> 16) % line_size);
            a1 = int'((next_random() >> 16) % line_size);
            proc_req.s0 = s_width'(a0);
            proc_req.s1 = s_width'(a1);
        end
        next_cycle();
        if (proc_line >= 0)
        begin
            check_sample(proc_line, a0, proc_data.v0, 0);
            check_sample(proc_line, a1, proc_data.v1, 1);
        end
    endtask

    task automatic load_line(input int line, input int proc_line);
        for (int i = 0; i < line_size; i++)
        begin
            load_we = 1'b1;
            load_addr = s_width'(i);
            load_data = vectors[line * 2 * line_size + i];
            step(proc_line);
        end
        load_we = 1'b0;
    endtask

    // kick a fill and run until fill_done has stayed high for a while
    task automatic run_fill(input int proc_line, input bit disturb);
        int   cycle;
        int   settle;
        int   rises;
        logic done_prev;
        cycle = 0;
        settle = 0;
        rises = 0;
        fill_kick = 1'b1;
        next_cycle();
        fill_kick = 1'b0;
        while (settle < settle_cycles)
        begin
            if (disturb)
            begin
                // both pulses land well inside the fill
                swap = (cycle == 5);
                fill_kick = (cycle == 15);
            end
            done_prev = fill_done;
            step(proc_line);
            if (fill_done && !done_prev)
                rises++;
            settle = fill_done ? settle + 1 : 0;
            cycle++;
        end
        swap = 1'b0;
        fill_kick = 1'b0;
        checks++;
        assert (rises == 1)
        else
        begin
            errors++;
            $display("FAILED at %0t ns: fill_done rose %0d times during one fill", $time, rises);
        end
    endtask

    task automatic swap_banks();
        swap = 1'b1;
        next_cycle();
        swap = 1'b0;
    endtask

    // every address once per port, each port in its own shuffled order
    task automatic read_all(input int line);
        int order [2][line_size];
        int j;
        int tmp;
        for (int p = 0; p < 2; p++)
        begin
            for (int i = 0; i < line_size; i++)
                order[p][i] = i;
            for (int i = line_size - 1; i > 0; i--)
            begin
                j = int'((next_random() >> 16) % 32'(i + 1));
                tmp = order[p][i];
                order[p][i] = order[p][j];
                order[p][j] = tmp;
            end
        end
        for (int i = 0; i < line_size; i++)
        begin
            proc_req.s0 = s_width'(order[0][i]);
            proc_req.s1 = s_width'(order[1][i]);
            next_cycle();
            check_sample(line, order[0][i], proc_data.v0, 0);
            check_sample(line, order[1][i], proc_data.v1, 1);
        end
    endtask

    initial
    begin
        errors = 0;
        checks = 0;
        lcg_state = 32'h8489c0d2;
        reset_n = 1'b1;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        fill_kick = 1'b0;
        swap = 1'b0;
        proc_req = '0;
        $readmemh("test/filter_vectors.txt", vectors);

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset_n = 1'b0;
        next_cycle();

        checks++;
        assert (fill_done === 1'b1)
        else
        begin
            errors++;
            $display("FAILED at %0t ns: fill_done is %b after reset", $time, fill_done);
        end

        // line A goes to bank 1 and becomes the processing bank
        load_line(0, -1);
        run_fill(-1, 1'b0);
        swap_banks();
        read_all(0);

        // line B fills bank 0 while bank 1 keeps serving line A
        load_line(1, 0);
        run_fill(0, 1'b1);
        swap_banks();
        read_all(1);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: hdl/projection_filter_top.sv
`timescale 1ns/1ps

module projection_filter_top
(
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    load_we,
    input  logic [filter_pkg::s_width-1:0]          load_addr,
    input  logic signed [filter_pkg::raw_width-1:0] load_data,
    input  logic                                    fill_kick,
    output logic                                    fill_done,
    input  logic                                    swap,
    input  filter_pkg::proc_req_t                   proc_req,
    output filter_pkg::proc_data_t                  proc_data
);

    import filter_pkg::*;

    logic [s_width-1:0] line_addr;
    logic [s_width-1:0] s_val_0;
    logic [s_width-1:0] s_val_1;

    logic signed [raw_width-1:0]  line_sample;
    logic signed [filt_width-1:0] hs_val;

    logic tap_clear;
    logic kick_0;
    logic kick_1;
    logic fill_done_0;
    logic fill_done_1;

    proc_req_t req_0;
    proc_req_t req_1;

    logic signed [filt_width-1:0] v0_0;
    logic signed [filt_width-1:0] v1_0;
    logic signed [filt_width-1:0] v0_1;
    logic signed [filt_width-1:0] v1_1;

    // an idle bank parks its read address at zero
    assign line_addr = s_val_0 | s_val_1;

    // raw line store, host on port 0, fill reads on port 1
    dual_port_ram #(
        .data_width (raw_width)
    ) u_line_store (
        .clk        (clk),
        .we_0       (load_we),
        .addr_0     (load_addr),
        .data_in_0  (load_data),
        .data_out_0 (),
        .we_1       (1'b0),
        .addr_1     (line_addr),
        .data_in_1  ('0),
        .data_out_1 (line_sample)
    );

    fir_filter u_fir (
        .clk       (clk),
        .reset_n   (reset_n),
        .tap_clear (tap_clear),
        .sample    (line_sample),
        .filtered  (hs_val)
    );

    bank_swap_ctrl u_swap (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_kick   (fill_kick),
        .swap        (swap),
        .fill_done_0 (fill_done_0),
        .fill_done_1 (fill_done_1),
        .proc_req    (proc_req),
        .proc_v0_0   (v0_0),
        .proc_v1_0   (v1_0),
        .proc_v0_1   (v0_1),
        .proc_v1_1   (v1_1),
        .kick_0      (kick_0),
        .kick_1      (kick_1),
        .tap_clear   (tap_clear),
        .req_0       (req_0),
        .req_1       (req_1),
        .proc_data   (proc_data),
        .fill_done   (fill_done)
    );

    filtered_ram_swappable u_bank_0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .hs_fill_kick (kick_0),
        .hs_val       (hs_val),
        .pr0_s_val    (req_0.s0),
        .pr1_s_val    (req_0.s1),
        .hs_fill_done (fill_done_0),
        .hs_s_val     (s_val_0),
        .pr0_val      (v0_0),
        .pr1_val      (v1_0)
    );

    filtered_ram_swappable u_bank_1 (
        .clk          (clk),
        .reset_n      (reset_n),
        .hs_fill_kick (kick_1),
        .hs_val       (hs_val),
        .pr0_s_val    (req_1.s0),
        .pr1_s_val    (req_1.s1),
        .hs_fill_done (fill_done_1),
        .hs_s_val     (s_val_1),
        .pr0_val      (v0_1),
        .pr1_val      (v1_1)
    );

endmodule

// File: hdl/bank_swap_ctrl.sv
`timescale 1ns/1ps

module bank_swap_ctrl
(
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     fill_kick,
    input  logic                                     swap,
    input  logic                                     fill_done_0,
    input  logic                                     fill_done_1,
    input  filter_pkg::proc_req_t                    proc_req,
    input  logic signed [filter_pkg::filt_width-1:0] proc_v0_0,
    input  logic signed [filter_pkg::filt_width-1:0] proc_v1_0,
    input  logic signed [filter_pkg::filt_width-1:0] proc_v0_1,
    input  logic signed [filter_pkg::filt_width-1:0] proc_v1_1,
    output logic                                     kick_0,
    output logic                                     kick_1,
    output logic                                     tap_clear,
    output filter_pkg::proc_req_t                    req_0,
    output filter_pkg::proc_req_t                    req_1,
    output filter_pkg::proc_data_t                   proc_data,
    output logic                                     fill_done
);

    import filter_pkg::*;

    // bank currently serving processing reads
    logic proc_bank;
    logic fill_bank;
    logic proc_idle;
    logic swap_ok;
    logic kick_ok;

    assign fill_done = proc_bank ? fill_done_0 : fill_done_1;
    assign proc_idle = proc_bank ? fill_done_1 : fill_done_0;

    assign swap_ok = swap && fill_done;
    assign kick_ok = fill_kick && fill_done;

    // kick together with a swap goes to the bank being released
    assign fill_bank = swap_ok ? proc_bank : ~proc_bank;
    assign kick_0 = kick_ok && !fill_bank;
    assign kick_1 = kick_ok && fill_bank;
    assign tap_clear = kick_ok;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            proc_bank <= 1'b0;
        else if (swap_ok)
            proc_bank <= ~proc_bank;
    end

    always_comb
    begin
        req_0 = '0;
        req_1 = '0;
        if (proc_bank)
            req_1 = proc_req;
        else
            req_0 = proc_req;
        proc_data.v0 = proc_bank ? proc_v0_1 : proc_v0_0;
        proc_data.v1 = proc_bank ? proc_v1_1 : proc_v1_0;
    end

    // no swap ever hands a bank to processing in the middle of a fill
    assert property (@(posedge clk) disable iff (reset_n) proc_idle)
        else $error("processing bank %0d is filling", proc_bank);

endmodule

// File: hdl/filtered_ram_swappable.sv
`timescale 1ns/1ps

module filtered_ram_swappable
(
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     hs_fill_kick,
    input  logic signed [filter_pkg::filt_width-1:0] hs_val,
    input  logic [filter_pkg::s_width-1:0]           pr0_s_val,
    input  logic [filter_pkg::s_width-1:0]           pr1_s_val,
    output logic                                     hs_fill_done,
    output logic [filter_pkg::s_width-1:0]           hs_s_val,
    output logic signed [filter_pkg::filt_width-1:0] pr0_val,
    output logic signed [filter_pkg::filt_width-1:0] pr1_val
);

    import filter_pkg::*;

    fill_state_t state;
    fill_state_t next_state;

    logic [s_width-1:0] read_itr;
    logic [s_width-1:0] read_next;
    logic [s_width-1:0] write_itr;
    logic [s_width-1:0] write_next;
    logic [s_width-1:0] port0_addr;

    logic write_itr_done;
    logic delay_done;
    logic write_enable;

    assign write_itr_done = (write_itr == s_width'(line_size - 1));
    assign delay_done = (read_itr == s_width'(fill_delay));
    assign write_enable = (state == fill_s);

    // Mealy done goes high already on the last write of a fill
    assign hs_fill_done = (state == ready_s) || (state == fill_s && write_itr_done);

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (hs_fill_kick)
                    next_state = delay_s;
            delay_s:
                if (delay_done)
                    next_state = fill_s;
            fill_s:
                if (write_itr_done)
                    next_state = hs_fill_kick ? delay_s : ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // read iterator saturates at line end so the last sample repeats
    always_comb
    begin
        read_next = read_itr;
        write_next = write_itr;
        case (state)
            delay_s:
                read_next = read_itr + 1'b1;
            fill_s:
                if (write_itr_done)
                begin
                    read_next = '0;
                    write_next = '0;
                end
                else
                begin
                    write_next = write_itr + 1'b1;
                    if (read_itr != s_width'(line_size - 1))
                        read_next = read_itr + 1'b1;
                end
            default:
            begin
                read_next = '0;
                write_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= ready_s;
            read_itr <= '0;
            write_itr <= '0;
        end
        else
        begin
            state <= next_state;
            read_itr <= read_next;
            write_itr <= write_next;
        end
    end

    // line store registers the address, so it sees the next value
    assign hs_s_val = read_next;

    // write iterator owns port 0 while a fill runs
    assign port0_addr = (state == ready_s) ? pr0_s_val : write_itr;

    dual_port_ram #(
        .data_width (filt_width)
    ) u_ram (
        .clk        (clk),
        .we_0       (write_enable),
        .addr_0     (port0_addr),
        .data_in_0  (hs_val),
        .data_out_0 (pr0_val),
        .we_1       (1'b0),
        .addr_1     (pr1_s_val),
        .data_in_1  ('0),
        .data_out_1 (pr1_val)
    );

    assert property (@(posedge clk) disable iff (reset_n)
        state inside {ready_s, delay_s, fill_s})
        else $error("fill state out of range: %0d", state);

    // writes trail the line store reads by fill_delay plus one until the reads hold at line end
    assert property (@(posedge clk) disable iff (reset_n)
        write_enable |-> read_itr == ((write_itr > s_width'(line_size - 2 - fill_delay)) ?
                                      s_width'(line_size - 1) :
                                      write_itr + s_width'(fill_delay + 1)))
        else $error("bank write %0d out of step with read %0d", write_itr, read_itr);

endmodule

// File: hdl/fir_filter.sv
`timescale 1ns/1ps

module fir_filter
(
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     tap_clear,
    input  logic signed [filter_pkg::raw_width-1:0]  sample,
    output logic signed [filter_pkg::filt_width-1:0] filtered
);

    import filter_pkg::*;

    // taps[0] is the previous sample, taps[fir_order-1] the oldest
    logic signed [raw_width-1:0]  taps [0:fir_order-1];
    logic signed [raw_width-1:0]  window [0:fir_order];
    logic signed [acc_width-1:0]  acc;
    logic signed [acc_width-1:0]  rounded;
    logic signed [filt_width-1:0] sat;

    // cleared taps stand in for samples before the line start
    always_ff @(posedge clk)
    begin
        if (reset_n || tap_clear)
        begin
            for (int i = 0; i < fir_order; i++)
                taps[i] <= '0;
        end
        else
        begin
            taps[0] <= sample;
            for (int i = 1; i < fir_order; i++)
                taps[i] <= taps[i-1];
        end
    end

    // newest sample first
    always_comb
    begin
        window[0] = sample;
        for (int i = 1; i <= fir_order; i++)
            window[i] = taps[i-1];
    end

    // fold symmetric pairs before the multiply
    always_comb
    begin
        logic signed [raw_width:0] pair;
        acc = window[fir_order/2] * fir_coefs[fir_order/2];
        for (int k = 0; k < fir_order / 2; k++)
        begin
            pair = window[k] + window[fir_order-k];
            acc = acc + pair * fir_coefs[k];
        end
    end

    // round half up then arithmetic shift
    assign rounded = (acc + $signed(acc_width'(1) << (coef_shift - 1))) >>> coef_shift;

    // clamp to the filtered range
    always_comb
    begin
        if (rounded[acc_width-1:filt_width-1] == '0 ||
            rounded[acc_width-1:filt_width-1] == '1)
            sat = rounded[filt_width-1:0];
        else if (rounded[acc_width-1])
            sat = {1'b1, {(filt_width-1){1'b0}}};
        else
            sat = {1'b0, {(filt_width-1){1'b1}}};
    end

    always_ff @(posedge clk)
    begin
        filtered <= sat;
    end

endmodule

// File: hdl/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram
#(
    parameter int data_width = 16
)
(
    input  logic                              clk,
    input  logic                              we_0,
    input  logic [filter_pkg::s_width-1:0]    addr_0,
    input  logic [data_width-1:0]             data_in_0,
    output logic [data_width-1:0]             data_out_0,
    input  logic                              we_1,
    input  logic [filter_pkg::s_width-1:0]    addr_1,
    input  logic [data_width-1:0]             data_in_1,
    output logic [data_width-1:0]             data_out_1
);

    import filter_pkg::*;

    logic [data_width-1:0] mem [0:line_size-1];

    // read returns the old word when a port writes its own address
    always_ff @(posedge clk)
    begin
        if (we_0)
            mem[addr_0] <= data_in_0;
        if (we_1)
            mem[addr_1] <= data_in_1;
        data_out_0 <= mem[addr_0];
        data_out_1 <= mem[addr_1];
    end

    // colliding writes would leave the word undefined
    assert property (@(posedge clk) !(we_0 && we_1 && addr_0 == addr_1))
        else $error("both ports write address %0d", addr_0);

endmodule

// File: hdl/filter_pkg.sv
package filter_pkg;

    // projection line geometry
    localparam int line_size = 32;
    localparam int s_width = 5;

    // sample widths, both signed
    localparam int raw_width = 16;
    localparam int filt_width = 16;

    // ramp filter
    localparam int fir_order = 8;
    localparam int coef_width = 12;
    localparam int coef_shift = 10;

    // pair sum bit, product, and growth over the five summed terms
    localparam int acc_width = raw_width + 1 + coef_width + 3;

    // read steps before the first write into a bank
    localparam int fill_delay = fir_order / 2;

    // discrete ramp kernel scaled by 2**coef_shift, centre at fir_order/2
    localparam logic signed [coef_width-1:0] fir_coefs [0:fir_order] = '{
        12'sd0, -12'sd46, 12'sd0, -12'sd415, 12'sd1024,
        -12'sd415, 12'sd0, -12'sd46, 12'sd0
    };

    // processing read addresses, one per port
    typedef struct packed {
        logic [s_width-1:0] s0;
        logic [s_width-1:0] s1;
    } proc_req_t;

    // filtered samples returned to processing
    typedef struct packed {
        logic signed [filt_width-1:0] v0;
        logic signed [filt_width-1:0] v1;
    } proc_data_t;

    typedef enum logic [1:0] {
        ready_s,
        delay_s,
        fill_s
    } fill_state_t;

endpackage
